// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = spriteSceneTb
FILELIST  = spriteScene.f
OBJDIR    = obj_dir
PASS_MSG  = test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// ==== hw/frameTick.sv ====
// Divides the frame strobe into a one-cycle move tick on every fourth rising edge
`timescale 1ns/1ps
`default_nettype none

module frameTick import spriteGamePkg::*;
(
    input  logic Clk,
    input  logic arstN,
    input  logic frameClk,
    output logic moveTick
);

    logic       frameClkQ;
    logic       frameRise;   // Registered rising edge of frameClk
    logic [1:0] frameCount;

    // Edge detect
    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            frameClkQ <= 1'b0;
            frameRise <= 1'b0;
        end
        else
        begin
            frameClkQ <= frameClk;
            frameRise <= frameClk && !frameClkQ;
        end
    end

    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            frameCount <= 2'd0;
            moveTick   <= 1'b0;
        end
        else
        begin
            moveTick <= frameRise && (frameCount == 2'(FramesPerMove - 1));
            if (frameRise)
                frameCount <= frameCount + 2'd1;  // Wraps after the last edge of the group
        end
    end

endmodule

`default_nettype wire

// ==== hw/playerSprite.sv ====
// Player sprite steered by WASD keycodes, with pixel test and frame-indexed ROM address
`timescale 1ns/1ps
`default_nettype none

module playerSprite import spriteGamePkg::*;
(
    input  logic                Clk,
    input  logic                arstN,
    input  logic                moveTick,
    input  logic [7:0]          keycode,
    input  logic                attackOn,
    input  logic [8:0]          pixelX,
    input  logic [8:0]          pixelY,
    output spritePosT           playerPos,
    output spriteDirT           playerDir,
    output logic                playerHit,
    output logic [RomAddrW-1:0] playerAddr
);

    logic [8:0]          xMotion;   // Two's complement step
    logic [8:0]          yMotion;
    spriteDirT           nextDir;
    spritePosT           nextPos;
    logic                moving;
    logic [1:0]          stepCount;
    logic [1:0]          frameSub;  // Frame within the facing group
    logic [3:0]          frameIdx;
    logic [8:0]          dx;
    logic [8:0]          dy;

    // Key decode with bounds; a blocked key still turns the player
    always_comb
    begin
        xMotion = 9'd0;
        yMotion = 9'd0;
        nextDir = playerDir;
        case (keycode)
            KeyW:
            begin
                nextDir = DirUp;
                if (playerPos.y > YMin)
                    yMotion = -PlayerStep;
            end
            KeyS:
            begin
                nextDir = DirDown;
                if (playerPos.y + PlayerH < YMax)
                    yMotion = PlayerStep;
            end
            KeyA:
            begin
                nextDir = DirLeft;
                if (playerPos.x > XMin)
                    xMotion = -PlayerStep;
            end
            KeyD:
            begin
                nextDir = DirRight;
                if (playerPos.x + PlayerW < XMax)
                    xMotion = PlayerStep;
            end
            default:
            begin
                nextDir = playerDir;  // Unknown key, stand still
            end
        endcase
    end

    assign moving    = (xMotion != 9'd0) || (yMotion != 9'd0);
    assign nextPos.x = playerPos.x + xMotion;
    assign nextPos.y = playerPos.y + yMotion;

    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            playerPos <= PlayerStart;
            playerDir <= DirDown;
        end
        else if (moveTick)
        begin
            playerPos <= nextPos;
            playerDir <= nextDir;
        end
    end

    walkAnimator i_walkAnimator
    (
        .Clk       (Clk),
        .arstN     (arstN),
        .moveTick  (moveTick),
        .moving    (moving),
        .stepCount (stepCount)
    );

    // Pixel inside the player box, upper bound excluded
    assign playerHit = (pixelX >= playerPos.x) && (pixelX < playerPos.x + PlayerW) &&
                       (pixelY >= playerPos.y) && (pixelY < playerPos.y + PlayerH);

    // Attack frame wins over the walk cycle
    always_comb
    begin
        if (attackOn)
            frameSub = 2'd3;
        else if (!stepCount[0])
            frameSub = 2'd0;
        else
            frameSub = {1'b0, stepCount[1]} + 2'd1;
    end

    assign frameIdx = {playerDir, frameSub};  // 4 * facing + sub frame
    assign dx       = pixelX - playerPos.x;
    assign dy       = pixelY - playerPos.y;

    assign playerAddr = RomAddrW'(dx) + RomAddrW'(dy) * RomAddrW'(PlayerW) +
                        PlayerFrameWords * RomAddrW'(frameIdx);

endmodule

`default_nettype wire

// ==== hw/spriteCompositor.sv ====
// Picks the owning layer and ROM address for the current pixel and flags sprite overlap
`timescale 1ns/1ps
`default_nettype none

module spriteCompositor import spriteGamePkg::*;
(
    input  spritePosT           playerPos,
    input  spritePosT           targetPos,
    input  logic                playerHit,
    input  logic                targetHit,
    input  logic [RomAddrW-1:0] playerAddr,
    input  logic [RomAddrW-1:0] targetAddr,
    output layerSelT            layer,
    output logic [RomAddrW-1:0] romAddr,
    output logic                hit
);

    logic xOverlap;
    logic yOverlap;

    // Player is drawn in front of the target
    always_comb
    begin
        if (playerHit)
        begin
            layer   = LayerPlayer;
            romAddr = playerAddr;
        end
        else if (targetHit)
        begin
            layer   = LayerTarget;
            romAddr = targetAddr;
        end
        else
        begin
            layer   = LayerNone;
            romAddr = '0;
        end
    end

    // Box overlap on each axis, half-open intervals
    assign xOverlap = (playerPos.x < targetPos.x + TargetW) &&
                      (targetPos.x < playerPos.x + PlayerW);
    assign yOverlap = (playerPos.y < targetPos.y + TargetH) &&
                      (targetPos.y < playerPos.y + PlayerH);

    assign hit = xOverlap && yOverlap;

endmodule

`default_nettype wire

// ==== hw/spriteGamePkg.sv ====
// Shared types, keycodes and screen constants for the sprite scene, imported by each module
`default_nettype none

package spriteGamePkg;

    // Upper left corner of a sprite
    typedef struct packed {
        logic [8:0] x;
        logic [8:0] y;
    } spritePosT;

    // Player facing, also the row group in the sprite sheet
    typedef enum logic [1:0] {
        DirDown  = 2'd0,
        DirLeft  = 2'd1,
        DirUp    = 2'd2,
        DirRight = 2'd3
    } spriteDirT;

    typedef enum logic [1:0] {
        LayerNone,
        LayerPlayer,
        LayerTarget
    } layerSelT;

    // Keyboard usage codes for WASD
    localparam logic [7:0] KeyW = 8'd26;
    localparam logic [7:0] KeyS = 8'd22;
    localparam logic [7:0] KeyA = 8'd4;
    localparam logic [7:0] KeyD = 8'd7;

    // Play box limits
    localparam logic [8:0] XMin = 9'd1;
    localparam logic [8:0] XMax = 9'd319;
    localparam logic [8:0] YMin = 9'd52;
    localparam logic [8:0] YMax = 9'd205;

    localparam logic [8:0] PlayerW    = 9'd18;
    localparam logic [8:0] PlayerH    = 9'd20;
    localparam logic [8:0] PlayerStep = 9'd3;
    localparam spritePosT  PlayerStart = '{x: 9'd151, y: 9'd110};

    localparam logic [8:0] TargetW    = 9'd12;
    localparam logic [8:0] TargetH    = 9'd12;
    localparam logic [8:0] TargetStep = 9'd2;
    localparam spritePosT  TargetStart = '{x: 9'd40, y: 9'd60};

    localparam int unsigned RomAddrW = 13;
    localparam logic [RomAddrW-1:0] PlayerFrameWords = RomAddrW'(PlayerW * PlayerH);
    localparam logic [RomAddrW-1:0] TargetRomBase    = 13'd5760;  // After 16 player frames

    localparam int unsigned FramesPerMove = 4;  // Frame edges per move tick

endpackage

`default_nettype wire

// ==== hw/spriteScene.sv ====
// Top level of the sprite scene: move tick, player, target and compositor
`timescale 1ns/1ps
`default_nettype none

module spriteScene import spriteGamePkg::*;
(
    input  logic                Clk,
    input  logic                arstN,
    input  logic                frameClk,
    input  logic [7:0]          keycode,
    input  logic                attackOn,
    input  logic [8:0]          pixelX,
    input  logic [8:0]          pixelY,
    output layerSelT            layer,
    output logic [RomAddrW-1:0] romAddr,
    output logic                hit,
    output spritePosT           playerPos,
    output spritePosT           targetPos,
    output spriteDirT           playerDir
);

    logic                moveTick;
    logic                playerHit;
    logic                targetHit;
    logic [RomAddrW-1:0] playerAddr;
    logic [RomAddrW-1:0] targetAddr;

    frameTick i_frameTick
    (
        .Clk      (Clk),
        .arstN    (arstN),
        .frameClk (frameClk),
        .moveTick (moveTick)
    );

    playerSprite i_playerSprite
    (
        .Clk        (Clk),
        .arstN      (arstN),
        .moveTick   (moveTick),
        .keycode    (keycode),
        .attackOn   (attackOn),
        .pixelX     (pixelX),
        .pixelY     (pixelY),
        .playerPos  (playerPos),
        .playerDir  (playerDir),
        .playerHit  (playerHit),
        .playerAddr (playerAddr)
    );

    targetSprite i_targetSprite
    (
        .Clk        (Clk),
        .arstN      (arstN),
        .moveTick   (moveTick),
        .pixelX     (pixelX),
        .pixelY     (pixelY),
        .targetPos  (targetPos),
        .targetHit  (targetHit),
        .targetAddr (targetAddr)
    );

    spriteCompositor i_spriteCompositor
    (
        .playerPos  (playerPos),
        .targetPos  (targetPos),
        .playerHit  (playerHit),
        .targetHit  (targetHit),
        .playerAddr (playerAddr),
        .targetAddr (targetAddr),
        .layer      (layer),
        .romAddr    (romAddr),
        .hit        (hit)
    );

endmodule

`default_nettype wire

// ==== hw/targetSprite.sv ====
// Target sprite bouncing diagonally in the play box, with pixel test and ROM address
`timescale 1ns/1ps
`default_nettype none

module targetSprite import spriteGamePkg::*;
(
    input  logic                Clk,
    input  logic                arstN,
    input  logic                moveTick,
    input  logic [8:0]          pixelX,
    input  logic [8:0]          pixelY,
    output spritePosT           targetPos,
    output logic                targetHit,
    output logic [RomAddrW-1:0] targetAddr
);

    logic       xNeg;       // Per-axis sign, 0 is moving up the axis
    logic       yNeg;
    logic [9:0] xNext;      // {sign, position}
    logic [9:0] yNext;
    logic [8:0] dx;
    logic [8:0] dy;

    // One axis step, reflecting at lo and hi
    function automatic logic [9:0] bounceStep(
        input logic [8:0] pos,
        input logic       neg,
        input logic [8:0] lo,
        input logic [8:0] hi
    );
        logic [9:0] result;
        if (!neg)
        begin
            if (pos + TargetStep > hi)
                result = {1'b1, pos - TargetStep};
            else
                result = {1'b0, pos + TargetStep};
        end
        else
        begin
            // Compare before subtracting so the low edge cannot wrap
            if (pos < lo + TargetStep)
                result = {1'b0, pos + TargetStep};
            else
                result = {1'b1, pos - TargetStep};
        end
        return result;
    endfunction

    assign xNext = bounceStep(targetPos.x, xNeg, XMin, XMax - TargetW);
    assign yNext = bounceStep(targetPos.y, yNeg, YMin, YMax - TargetH);

    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            targetPos <= TargetStart;
            xNeg      <= 1'b0;
            yNeg      <= 1'b0;
        end
        else if (moveTick)
        begin
            {xNeg, targetPos.x} <= xNext;
            {yNeg, targetPos.y} <= yNext;
        end
    end

    assign targetHit = (pixelX >= targetPos.x) && (pixelX < targetPos.x + TargetW) &&
                       (pixelY >= targetPos.y) && (pixelY < targetPos.y + TargetH);

    assign dx = pixelX - targetPos.x;
    assign dy = pixelY - targetPos.y;

    // Single frame sheet after the player frames
    assign targetAddr = TargetRomBase + RomAddrW'(dx) + RomAddrW'(dy) * RomAddrW'(TargetW);

endmodule

`default_nettype wire

// ==== hw/walkAnimator.sv ====
// Counts consecutive walking move ticks to drive the player's walk cycle
`timescale 1ns/1ps
`default_nettype none

module walkAnimator
(
    input  logic       Clk,
    input  logic       arstN,
    input  logic       moveTick,
    input  logic       moving,
    output logic [1:0] stepCount
);

    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            stepCount <= 2'd0;
        end
        else if (moveTick)
        begin
            // Standing still for a tick restarts the cycle
            if (moving)
                stepCount <= stepCount + 2'd1;
            else
                stepCount <= 2'd0;
        end
    end

endmodule

`default_nettype wire

// ==== spriteScene.f ====
hw/spriteGamePkg.sv
hw/frameTick.sv
hw/walkAnimator.sv
hw/playerSprite.sv
hw/targetSprite.sv
hw/spriteCompositor.sv
hw/spriteScene.sv
verification/spriteSceneTb.sv

// ==== verification/spriteSceneTb.sv ====
// Table-driven testbench for the sprite scene, built and run through the Makefile
`timescale 1ns/1ps
`default_nettype none

module spriteSceneTb import spriteGamePkg::*;
();

    localparam int TickTimeout = 12;  // Cycles from the 4th frame pulse to the position update

    // One stimulus row with the hand-computed expected outputs after its last tick
    typedef struct packed {
        logic [7:0]          key;
        logic                attack;
        logic [7:0]          ticks;
        logic [8:0]          pixX;
        logic [8:0]          pixY;
        spritePosT           pos;
        spriteDirT           dir;
        layerSelT            layer;
        logic [RomAddrW-1:0] addr;
    } stimRowT;

    logic                Clk;
    logic                arstN;
    logic                frameClk;
    logic [7:0]          keycode;
    logic                attackOn;
    logic [8:0]          pixelX;
    logic [8:0]          pixelY;
    layerSelT            layer;
    logic [RomAddrW-1:0] romAddr;
    logic                hit;
    spritePosT           playerPos;
    spritePosT           targetPos;
    spriteDirT           playerDir;

    stimRowT     rowQ[$];
    logic [31:0] lfsrState;
    int          modelX;     // Target model corner and signs
    int          modelY;
    bit          modelXNeg;
    bit          modelYNeg;
    int          tickCount;
    int          checkCount;
    int          errorCount;
    int          timeoutCount;

    spriteScene i_spriteScene (.*);

    initial
    begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;
    end

    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        if (state[0])
            return (state >> 1) ^ 32'hD0000001;
        return state >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic int takeBits(input int count);
        int value;
        value = 0;
        for (int i = 0; i < count; i++)
        begin
            lfsrState = lfsrNext(lfsrState);
            value     = (value << 1) | int'(lfsrState[0]);
        end
        return value;
    endfunction

    task automatic addRow(input logic [7:0] key, input logic attack, input int ticks,
                          input int pixX, input int pixY, input int expX, input int expY,
                          input spriteDirT dir, input layerSelT lay, input int addr);
        stimRowT r;
        r.key    = key;
        r.attack = attack;
        r.ticks  = 8'(ticks);
        r.pixX   = 9'(pixX);
        r.pixY   = 9'(pixY);
        r.pos.x  = 9'(expX);
        r.pos.y  = 9'(expY);
        r.dir    = dir;
        r.layer  = lay;
        r.addr   = RomAddrW'(addr);
        rowQ.push_back(r);
    endtask

    task automatic buildTable();
        //     key    atk  ticks pixel     player    facing    layer        romAddr
        addRow(8'd0, 1'b0, 0,  300, 20,  151, 110, DirDown,  LayerNone,   0);     // Reset
        addRow(KeyD, 1'b0, 1,  159, 112, 154, 110, DirRight, LayerPlayer, 4721);  // Frame 13
        addRow(KeyD, 1'b0, 1,  157, 110, 157, 110, DirRight, LayerPlayer, 4320);  // Frame 12
        addRow(KeyD, 1'b0, 1,  177, 129, 160, 110, DirRight, LayerPlayer, 5399);  // Frame 14
        addRow(8'd0, 1'b0, 1,  161, 111, 160, 110, DirRight, LayerPlayer, 4339);  // Idle
        addRow(8'd0, 1'b1, 1,  162, 113, 160, 110, DirRight, LayerPlayer, 5456);  // Attack
        addRow(KeyA, 1'b0, 1,  160, 114, 157, 110, DirLeft,  LayerPlayer, 1875);
        addRow(KeyA, 1'b0, 22, 100, 120, 91,  110, DirLeft,  LayerPlayer, 2349);  // Both boxes
        addRow(8'd0, 1'b0, 1,  109, 125, 91,  110, DirLeft,  LayerTarget, 5855);
        addRow(KeyW, 1'b0, 22, 95,  55,  91,  50,  DirUp,    LayerPlayer, 2974);  // Hits YMin
        addRow(KeyW, 1'b1, 3,  91,  50,  91,  50,  DirUp,    LayerPlayer, 3960);  // Blocked
        addRow(8'd0, 1'b0, 16, 181, 190, 91,  50,  DirUp,    LayerTarget, 5833);  // Y bounce
        addRow(KeyS, 1'b0, 2,  93,  57,  91,  56,  DirDown,  LayerPlayer, 20);
        // Long run through the X bounce and the low Y bounce
        addRow(8'd0, 1'b0, 68, 300, 65,  91,  56,  DirDown,  LayerTarget, 5828);
    endtask

    task automatic checkValue(input string name, input int actual, input int expected);
        checkCount++;
        assert (actual == expected)
        else
        begin
            $display("error at %0d ns: %s expected %0d, actual %0d",
                     $time, name, expected, actual);
            errorCount++;
        end
    endtask

    // Signed step on one axis, reversing when the step would leave lo..hi
    task automatic stepAxis(inout int pos, inout bit neg, input int lo, input int hi);
        int step;
        int next;
        step = int'(TargetStep);
        next = neg ? pos - step : pos + step;
        if (next < lo || next > hi)
        begin
            neg  = !neg;
            next = neg ? pos - step : pos + step;
        end
        pos = next;
    endtask

    task automatic advanceTargetModel();
        stepAxis(modelX, modelXNeg, int'(XMin), int'(XMax) - int'(TargetW));
        stepAxis(modelY, modelYNeg, int'(YMin), int'(YMax) - int'(TargetH));
        tickCount++;
    endtask

    function automatic bit boxesOverlap(input int px, input int py, input int tx, input int ty);
        return (px < tx + int'(TargetW)) && (tx < px + int'(PlayerW)) &&
               (py < ty + int'(TargetH)) && (ty < py + int'(PlayerH));
    endfunction

    // High for 1 to 4 cycles, then low for 1 to 4 cycles
    task automatic pulseFrame();
        int highCycles;
        int lowCycles;
        highCycles = takeBits(2) + 1;
        lowCycles  = takeBits(2) + 1;
        @(posedge Clk);
        frameClk <= 1'b1;
        repeat (highCycles) @(posedge Clk);
        frameClk <= 1'b0;
        repeat (lowCycles - 1) @(posedge Clk);
    endtask

    task automatic runMoveTick(input int idx);
        spritePosT prevPlayer;
        spritePosT prevTarget;
        int        cycles;
        prevPlayer = playerPos;
        prevTarget = targetPos;
        repeat (3) pulseFrame();
        repeat (3) @(negedge Clk);  // Room for an early tick to show
        checkValue("playerPos after 3 edges", int'(playerPos), int'(prevPlayer));
        checkValue("targetPos after 3 edges", int'(targetPos), int'(prevTarget));
        pulseFrame();
        advanceTargetModel();
        cycles = 0;
        do
        begin
            @(negedge Clk);
            cycles++;
        end
        while (targetPos == prevTarget && cycles < TickTimeout);
        if (targetPos == prevTarget)
        begin
            $display("timeout: positions did not update after the fourth frame pulse in row %0d",
                     idx);
            timeoutCount++;
        end
    endtask

    task automatic applyRow(input int idx);
        stimRowT r;
        r = rowQ[idx];
        @(posedge Clk);
        keycode  <= r.key;
        attackOn <= r.attack;
        pixelX   <= r.pixX;
        pixelY   <= r.pixY;
        for (int t = 0; t < int'(r.ticks); t++)
            runMoveTick(idx);
        @(negedge Clk);
        checkValue("playerPos.x", int'(playerPos.x), int'(r.pos.x));
        checkValue("playerPos.y", int'(playerPos.y), int'(r.pos.y));
        checkValue("playerDir", int'(playerDir), int'(r.dir));
        checkValue("targetPos.x", int'(targetPos.x), modelX);
        checkValue("targetPos.y", int'(targetPos.y), modelY);
        checkValue("layer", int'(layer), int'(r.layer));
        checkValue("romAddr", int'(romAddr), int'(r.addr));
        checkValue("hit", int'(hit),
                   int'(boxesOverlap(int'(r.pos.x), int'(r.pos.y), modelX, modelY)));
    endtask

    initial
    begin
        arstN        = 1'b0;
        frameClk     = 1'b0;
        keycode      = 8'd0;
        attackOn     = 1'b0;
        pixelX       = 9'd0;
        pixelY       = 9'd0;
        lfsrState    = 32'h6962f996;
        modelX       = 40;  // Target start corner, both signs positive
        modelY       = 60;
        modelXNeg    = 1'b0;
        modelYNeg    = 1'b0;
        tickCount    = 0;
        checkCount   = 0;
        errorCount   = 0;
        timeoutCount = 0;
        buildTable();
        repeat (5) @(posedge Clk);
        arstN <= 1'b1;
        for (int i = 0; i < rowQ.size(); i++)
            applyRow(i);
        $display("%0d move ticks, %0d checks, %0d errors, %0d timeouts",
                 tickCount, checkCount, errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire
